// File: include/lpif_macros.svh
// Flit field widths and bit positions
// PHY word widths and user bit location, delay counter width
`ifndef LPIF_MACROS_SVH
`define LPIF_MACROS_SVH

// Flit field widths
`define LPIF_STATE_W        4
`define LPIF_PROTID_W       2
`define LPIF_DATA_W         128
`define LPIF_CRC_W          16
`define LPIF_FLIT_W         153

// Flit bit positions, counted from the LSB
`define LPIF_VALID_POS      0
`define LPIF_CRC_VALID_POS  1
`define LPIF_CRC_LSB        2
`define LPIF_DVALID_POS     (`LPIF_CRC_LSB + `LPIF_CRC_W)
`define LPIF_DATA_LSB       (`LPIF_DVALID_POS + 1)
`define LPIF_PROTID_LSB     (`LPIF_DATA_LSB + `LPIF_DATA_W)
`define LPIF_STATE_LSB      (`LPIF_PROTID_LSB + `LPIF_PROTID_W)

// PHY words
`define LPIF_PHY_W          80
`define LPIF_PHY0_FLIT_W    77
`define LPIF_PHY1_FLIT_W    76
`define LPIF_USERBIT_POS    79

// Control and status
`define LPIF_DELAY_W        8
`define LPIF_STATUS_W       32

`endif

// File: hw/lpif_pkg.sv
// Shared types of the die-to-die link
// Link state, protocol id, data, CRC and the packed flit
`default_nettype none

`include "lpif_macros.svh"

package lpif_pkg;

  //////////////////////////////////////////////////////////////////////
  // Channel field types
  //////////////////////////////////////////////////////////////////////

  // Link state, carried end to end without decoding
  typedef logic [`LPIF_STATE_W-1:0]  lpif_state_t;

  // Protocol id of the flit
  typedef logic [`LPIF_PROTID_W-1:0] lpif_protid_t;

  // Flit payload
  typedef logic [`LPIF_DATA_W-1:0]   lpif_data_t;

  // CRC over the payload, computed upstream of this layer
  typedef logic [`LPIF_CRC_W-1:0]    lpif_crc_t;

  //////////////////////////////////////////////////////////////////////
  // Flit
  //////////////////////////////////////////////////////////////////////

  // Packed flit, LSB first:
  //   valid, crc_valid, crc, dvalid, data, protid, state
  typedef logic [`LPIF_FLIT_W-1:0]   lpif_flit_t;

  // Debug status word
  typedef logic [`LPIF_STATUS_W-1:0] lpif_status_t;

endpackage

`default_nettype wire

// File: hw/lpif_auto_sync.sv
// Online delay counters for both link directions
// Registered strobe and marker user bits
`timescale 1ns/1ps
`default_nettype none

`include "lpif_macros.svh"

module lpif_auto_sync (
  input  logic                     clk_wr,
  input  logic                     arst_n,

  // Raw online indications
  input  logic                     tx_online,
  input  logic                     rx_online,

  // Programmed delays in clk_wr cycles
  input  logic [`LPIF_DELAY_W-1:0] delay_x_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_xz_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_yz_value,

  // User bits from the configuration
  input  logic                     tx_stb_userbit,
  input  logic                     tx_mrk_userbit,

  // Delayed online indications
  output logic                     tx_online_delay,
  output logic                     rx_online_delay,

  // User bits towards the PHY words
  output logic                     tx_auto_stb_userbit,
  output logic                     tx_auto_mrk_userbit
);

  // One extra bit so xz + yz never overflows
  localparam int CNT_W = `LPIF_DELAY_W + 1;

  // Index 0 is the tx direction, index 1 the rx direction
  localparam int DIR_N = 2;

  logic [DIR_N-1:0]            online_in;
  logic [DIR_N-1:0][CNT_W-1:0] target;
  logic [DIR_N-1:0][CNT_W-1:0] cnt_q;
  logic [DIR_N-1:0]            online_q;
  logic                        stb_q;
  logic                        mrk_q;

  //////////////////////////////////////////////////////////////////////
  // Delay targets
  //////////////////////////////////////////////////////////////////////

  assign online_in = {rx_online, tx_online};

  // Tx waits for both the xz and the yz phase
  assign target[0] = CNT_W'(delay_xz_value) + CNT_W'(delay_yz_value);
  // Rx waits for word alignment only
  assign target[1] = CNT_W'(delay_x_value);

  //////////////////////////////////////////////////////////////////////
  // Saturating delay counters
  //////////////////////////////////////////////////////////////////////

  // Counter climbs while online and stops at its target
  // Delayed online goes high on the edge that sees the target reached
  // Dropping online clears both at once
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q    <= '0;
      online_q <= '0;
    end else begin
      for (int i = 0; i < DIR_N; i++) begin
        if (!online_in[i]) begin
          cnt_q[i]    <= '0;
          online_q[i] <= 1'b0;
        end else begin
          if (cnt_q[i] < target[i]) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
          end
          online_q[i] <= (cnt_q[i] >= target[i]);
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  //////////////////////////////////////////////////////////////////////
  // Persistent user bits
  //////////////////////////////////////////////////////////////////////

  // Sampled every cycle, independent of the online state
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_q <= 1'b0;
      mrk_q <= 1'b0;
    end else begin
      stb_q <= tx_stb_userbit;
      mrk_q <= tx_mrk_userbit;
    end
  end

  assign tx_auto_stb_userbit = stb_q;
  assign tx_auto_mrk_userbit = mrk_q;

endmodule

`default_nettype wire

// File: hw/lpif_flit_pack.sv
// Downstream flit packing and upstream flit unpacking
// Tx and rx debug status counters with sticky strobe loss flag
`timescale 1ns/1ps
`default_nettype none

`include "lpif_macros.svh"

module lpif_flit_pack (
  input  logic                  clk_wr,
  input  logic                  arst_n,

  // Downstream channel
  input  lpif_pkg::lpif_state_t  dstrm_state,
  input  lpif_pkg::lpif_protid_t dstrm_protid,
  input  lpif_pkg::lpif_data_t   dstrm_data,
  input  logic                   dstrm_dvalid,
  input  lpif_pkg::lpif_crc_t    dstrm_crc,
  input  logic                   dstrm_crc_valid,
  input  logic                   dstrm_valid,

  // Delayed online indications
  input  logic                   rx_online_delay,
  input  logic                   tx_online_delay,

  // Flits to and from the PHY mapping
  output lpif_pkg::lpif_flit_t   txfifo_downstream_data,
  input  lpif_pkg::lpif_flit_t   rx_upstream_data,
  input  logic                   rx_stb_error,

  // Upstream channel
  output lpif_pkg::lpif_state_t  ustrm_state,
  output lpif_pkg::lpif_protid_t ustrm_protid,
  output lpif_pkg::lpif_data_t   ustrm_data,
  output logic                   ustrm_dvalid,
  output lpif_pkg::lpif_crc_t    ustrm_crc,
  output logic                   ustrm_crc_valid,
  output logic                   ustrm_valid,

  // Debug status
  output lpif_pkg::lpif_status_t tx_downstream_debug_status,
  output lpif_pkg::lpif_status_t rx_upstream_debug_status
);

  lpif_pkg::lpif_flit_t          tx_flit_q;
  lpif_pkg::lpif_status_t        tx_cnt_q;
  logic [`LPIF_STATUS_W-2:0]     rx_cnt_q;
  logic                          stb_lost_q;
  logic                          rx_take;

  //////////////////////////////////////////////////////////////////////
  // Downstream packing
  //////////////////////////////////////////////////////////////////////

  // Concatenation order puts valid at bit 0 and state on top
  always_ff @(posedge clk_wr) begin
    tx_flit_q <= {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                  dstrm_crc, dstrm_crc_valid, dstrm_valid};
  end

  assign txfifo_downstream_data = tx_flit_q;

  // Same condition the PHY mapping uses to pass the flit on
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_cnt_q <= '0;
    end else if (tx_online_delay && tx_flit_q[`LPIF_VALID_POS]) begin
      tx_cnt_q <= tx_cnt_q + 1'b1;
    end
  end

  assign tx_downstream_debug_status = tx_cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Upstream unpacking
  //////////////////////////////////////////////////////////////////////

  // Received flit with valid set while the rx side is online
  assign rx_take = rx_online_delay && rx_upstream_data[`LPIF_VALID_POS];

  // All fields held at zero while offline
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= 1'b0;
      ustrm_valid     <= 1'b0;
    end else if (!rx_online_delay) begin
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= 1'b0;
      ustrm_valid     <= 1'b0;
    end else begin
      ustrm_state     <= rx_upstream_data[`LPIF_STATE_LSB +: `LPIF_STATE_W];
      ustrm_protid    <= rx_upstream_data[`LPIF_PROTID_LSB +: `LPIF_PROTID_W];
      ustrm_data      <= rx_upstream_data[`LPIF_DATA_LSB +: `LPIF_DATA_W];
      ustrm_dvalid    <= rx_upstream_data[`LPIF_DVALID_POS];
      ustrm_crc       <= rx_upstream_data[`LPIF_CRC_LSB +: `LPIF_CRC_W];
      ustrm_crc_valid <= rx_upstream_data[`LPIF_CRC_VALID_POS];
      ustrm_valid     <= rx_upstream_data[`LPIF_VALID_POS];
    end
  end

  // Flit count in the low bits, strobe loss latched in the MSB
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt_q   <= '0;
      stb_lost_q <= 1'b0;
    end else begin
      if (rx_take) begin
        rx_cnt_q <= rx_cnt_q + 1'b1;
      end
      if (rx_stb_error) begin
        stb_lost_q <= 1'b1;
      end
    end
  end

  assign rx_upstream_debug_status = {stb_lost_q, rx_cnt_q};

endmodule

`default_nettype wire

// File: hw/lpif_phy_concat.sv
// Flit to PHY word mapping for transmit
// PHY word to flit reassembly and strobe check for receive
`timescale 1ns/1ps
`default_nettype none

`include "lpif_macros.svh"

module lpif_phy_concat (
  input  logic                   clk_wr,
  input  logic                   arst_n,

  // Transmit side
  input  logic                   tx_online,
  input  lpif_pkg::lpif_flit_t   tx_downstream_data,
  input  logic                   tx_stb_userbit,
  input  logic                   tx_mrk_userbit,
  output logic [`LPIF_PHY_W-1:0] tx_phy0,
  output logic [`LPIF_PHY_W-1:0] tx_phy1,

  // Receive side
  input  logic [`LPIF_PHY_W-1:0] rx_phy0,
  input  logic [`LPIF_PHY_W-1:0] rx_phy1,
  input  logic                   rx_online,
  output lpif_pkg::lpif_flit_t   rx_upstream_data,
  output logic                   rx_stb_error
);

  lpif_pkg::lpif_flit_t          tx_flit;
  logic [`LPIF_PHY_W-1:0]        phy0_next;
  logic [`LPIF_PHY_W-1:0]        phy1_next;
  lpif_pkg::lpif_flit_t          rx_flit_q;
  logic                          stb_err_q;

  //////////////////////////////////////////////////////////////////////
  // Transmit mapping
  //////////////////////////////////////////////////////////////////////

  // Flit field blanked until the link is up
  assign tx_flit = tx_online ? tx_downstream_data : '0;

  // Word 0 takes the low flit bits and the strobe
  // Word 1 takes the rest and the marker
  // Spare bits between flit field and user bit stay zero
  always_comb begin
    phy0_next = '0;
    phy1_next = '0;
    phy0_next[`LPIF_PHY0_FLIT_W-1:0] = tx_flit[`LPIF_PHY0_FLIT_W-1:0];
    phy1_next[`LPIF_PHY1_FLIT_W-1:0] =
      tx_flit[`LPIF_PHY0_FLIT_W +: `LPIF_PHY1_FLIT_W];
    phy0_next[`LPIF_USERBIT_POS] = tx_stb_userbit;
    phy1_next[`LPIF_USERBIT_POS] = tx_mrk_userbit;
  end

  // Registered PHY words
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= phy0_next;
      tx_phy1 <= phy1_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive reassembly
  //////////////////////////////////////////////////////////////////////

  // Word 1 bits sit on top of word 0 bits
  always_ff @(posedge clk_wr) begin
    rx_flit_q <= {rx_phy1[`LPIF_PHY1_FLIT_W-1:0], rx_phy0[`LPIF_PHY0_FLIT_W-1:0]};
  end

  assign rx_upstream_data = rx_flit_q;

  //////////////////////////////////////////////////////////////////////
  // Strobe check
  //////////////////////////////////////////////////////////////////////

  // Strobe is persistent, so a zero while online means a lost word
  // One pulse per bad word, aligned with the reassembled flit
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_err_q <= 1'b0;
    end else begin
      stb_err_q <= rx_online && !rx_phy0[`LPIF_USERBIT_POS];
    end
  end

  assign rx_stb_error = stb_err_q;

endmodule

`default_nettype wire

// File: hw/lpif_link_top.sv
// Master side top level of the die-to-die link
// Auto sync, flit packing and PHY word mapping
`timescale 1ns/1ps
`default_nettype none

`include "lpif_macros.svh"

module lpif_link_top (
  input  logic                     clk_wr,
  input  logic                     arst_n,

  // Control
  input  logic                     tx_online,
  input  logic                     rx_online,

  // PHY interconnect
  output logic [`LPIF_PHY_W-1:0]   tx_phy0,
  input  logic [`LPIF_PHY_W-1:0]   rx_phy0,
  output logic [`LPIF_PHY_W-1:0]   tx_phy1,
  input  logic [`LPIF_PHY_W-1:0]   rx_phy1,

  // Downstream channel
  input  lpif_pkg::lpif_state_t    dstrm_state,
  input  lpif_pkg::lpif_protid_t   dstrm_protid,
  input  lpif_pkg::lpif_data_t     dstrm_data,
  input  logic                     dstrm_dvalid,
  input  lpif_pkg::lpif_crc_t      dstrm_crc,
  input  logic                     dstrm_crc_valid,
  input  logic                     dstrm_valid,

  // Upstream channel
  output lpif_pkg::lpif_state_t    ustrm_state,
  output lpif_pkg::lpif_protid_t   ustrm_protid,
  output lpif_pkg::lpif_data_t     ustrm_data,
  output logic                     ustrm_dvalid,
  output lpif_pkg::lpif_crc_t      ustrm_crc,
  output logic                     ustrm_crc_valid,
  output logic                     ustrm_valid,

  // Debug status
  output lpif_pkg::lpif_status_t   tx_downstream_debug_status,
  output lpif_pkg::lpif_status_t   rx_upstream_debug_status,

  // Configuration
  input  logic                     tx_mrk_userbit,
  input  logic                     tx_stb_userbit,
  input  logic [`LPIF_DELAY_W-1:0] delay_x_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_xz_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_yz_value
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////////////////////////

  lpif_pkg::lpif_flit_t txfifo_downstream_data;
  lpif_pkg::lpif_flit_t rx_upstream_data;
  logic                 rx_stb_error;
  logic                 tx_online_delay;
  logic                 rx_online_delay;
  logic                 tx_auto_stb_userbit;
  logic                 tx_auto_mrk_userbit;

  // Online delays and user bits
  lpif_auto_sync lpif_auto_sync_i (
    .clk_wr              (clk_wr),
    .arst_n              (arst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_xz_value      (delay_xz_value),
    .delay_yz_value      (delay_yz_value),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  // Channel side, both directions gated by the delayed online
  lpif_flit_pack lpif_flit_pack_i (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .rx_online_delay            (rx_online_delay),
    .tx_online_delay            (tx_online_delay),
    .txfifo_downstream_data     (txfifo_downstream_data),
    .rx_upstream_data           (rx_upstream_data),
    .rx_stb_error               (rx_stb_error),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  // PHY side, strobe checked against the raw rx online
  lpif_phy_concat lpif_phy_concat_i (
    .clk_wr             (clk_wr),
    .arst_n             (arst_n),
    .tx_online          (tx_online_delay),
    .tx_downstream_data (txfifo_downstream_data),
    .tx_stb_userbit     (tx_auto_stb_userbit),
    .tx_mrk_userbit     (tx_auto_mrk_userbit),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .rx_online          (rx_online),
    .rx_upstream_data   (rx_upstream_data),
    .rx_stb_error       (rx_stb_error)
  );

endmodule

`default_nettype wire

// File: tb/lpif_link_tb.sv
// Loopback testbench for the die-to-die link top level
// LFSR stimulus, cycle model of the link, per-test reporting
`timescale 1ns/1ps
`default_nettype none

`include "lpif_macros.svh"

module lpif_link_tb;

  localparam int FW = `LPIF_FLIT_W;
  localparam int PW = `LPIF_PHY_W;
  localparam int DLY_X = 2;
  localparam int DLY_XZ = 3;
  localparam int DLY_YZ = 4;
  localparam int WAIT_LIMIT = 40;
  localparam int RUN_CAP = 1000;
  localparam int W_TX_FLIT = 0;
  localparam int W_RX_FLIT = 1;
  localparam int W_STB_LOST = 2;

  typedef logic [FW-1:0] wide_t;

  logic                     clk;
  logic                     arst_n;
  logic                     tx_online;
  logic                     rx_online;
  logic [PW-1:0]            tx_phy0;
  logic [PW-1:0]            tx_phy1;
  lpif_pkg::lpif_state_t    dstrm_state;
  lpif_pkg::lpif_protid_t   dstrm_protid;
  lpif_pkg::lpif_data_t     dstrm_data;
  logic                     dstrm_dvalid;
  lpif_pkg::lpif_crc_t      dstrm_crc;
  logic                     dstrm_crc_valid;
  logic                     dstrm_valid;
  lpif_pkg::lpif_state_t    ustrm_state;
  lpif_pkg::lpif_protid_t   ustrm_protid;
  lpif_pkg::lpif_data_t     ustrm_data;
  logic                     ustrm_dvalid;
  lpif_pkg::lpif_crc_t      ustrm_crc;
  logic                     ustrm_crc_valid;
  logic                     ustrm_valid;
  lpif_pkg::lpif_status_t   tx_downstream_debug_status;
  lpif_pkg::lpif_status_t   rx_upstream_debug_status;
  logic                     tx_mrk_userbit;
  logic                     tx_stb_userbit;
  logic [`LPIF_DELAY_W-1:0] delay_x_value;
  logic [`LPIF_DELAY_W-1:0] delay_xz_value;
  logic [`LPIF_DELAY_W-1:0] delay_yz_value;

  // Next input values, applied on the rising edge
  logic  nxt_arst_n;
  logic  nxt_tx_online;
  logic  nxt_rx_online;
  logic  nxt_stb;
  logic  nxt_mrk;
  wide_t nxt_flit;

  // Model state
  wide_t       flit_q[$];
  logic        txd_q[$];
  logic        exp_rxd;
  wide_t       exp_phy_flit;
  wide_t       exp_ustrm;
  logic        exp_stb;
  logic        exp_mrk;
  logic        stb_prev;
  logic        mrk_prev;
  logic        exp_err;
  logic        exp_lost;
  logic [31:0] exp_tx_cnt;
  logic [31:0] exp_rx_cnt;
  int          tx_run;
  int          rx_run;
  int          edge_n;
  int          tx_rise_edge;
  int          rx_rise_edge;

  logic [31:0] lfsr;
  string       test_name;
  int          test_errs;
  int          pass_tests;
  int          fail_tests;
  logic [31:0] tx_start;
  logic [31:0] rx_start;
  logic [31:0] sent_valid;

  lpif_link_top lpif_link_top_i (
    .clk_wr                     (clk),
    .arst_n                     (arst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_phy0                    (tx_phy0),
    .rx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy1                    (tx_phy1),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .delay_x_value              (delay_x_value),
    .delay_xz_value             (delay_xz_value),
    .delay_yz_value             (delay_yz_value)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////////////////

  // Right-shifting Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic rand_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  function automatic wide_t rand_bits(input int n);
    wide_t r;
    int    i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r[i] = rand_bit();
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Model of the link, one call per sampled edge
  ////////////////////////////////////////////////////////////////////////

  task automatic model_edge();
    wide_t s_flit;
    logic  txd_new;
    logic  rxd_new;
    // Held in reset, expected values stay zero
    if (arst_n) begin
      edge_n++;
      s_flit = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                dstrm_crc, dstrm_crc_valid, dstrm_valid};
      // Strobe error shows one cycle before the sticky flag
      exp_lost = exp_lost | exp_err;
      exp_err = rx_online && !exp_stb;
      // User bits reach the PHY two cycles after they change
      exp_stb = stb_prev;
      exp_mrk = mrk_prev;
      stb_prev = tx_stb_userbit;
      mrk_prev = tx_mrk_userbit;
      if (!tx_online) begin
        tx_run = 0;
      end else if (tx_run < RUN_CAP) begin
        tx_run++;
      end
      if (!rx_online) begin
        rx_run = 0;
      end else if (rx_run < RUN_CAP) begin
        rx_run++;
      end
      if (tx_run == 1) begin
        tx_rise_edge = edge_n;
      end
      if (rx_run == 1) begin
        rx_rise_edge = edge_n;
      end
      txd_new = tx_online && (tx_run > int'(delay_xz_value) + int'(delay_yz_value));
      rxd_new = rx_online && (rx_run > int'(delay_x_value));
      // PHY carries the flit sampled one edge earlier
      exp_phy_flit = txd_q[0] ? flit_q[0] : '0;
      // Upstream gets the flit sampled three edges earlier
      exp_ustrm = (exp_rxd && txd_q[2]) ? flit_q[2] : '0;
      exp_tx_cnt = exp_tx_cnt + {31'b0, exp_phy_flit[`LPIF_VALID_POS]};
      exp_rx_cnt = exp_rx_cnt + {31'b0, exp_ustrm[`LPIF_VALID_POS]};
      flit_q.push_front(s_flit);
      void'(flit_q.pop_back());
      txd_q.push_front(txd_new);
      void'(txd_q.pop_back());
      exp_rxd = rxd_new;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Drive, check, wait
  ////////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    arst_n          <= nxt_arst_n;
    tx_online       <= nxt_tx_online;
    rx_online       <= nxt_rx_online;
    tx_stb_userbit  <= nxt_stb;
    tx_mrk_userbit  <= nxt_mrk;
    dstrm_valid     <= nxt_flit[`LPIF_VALID_POS];
    dstrm_crc_valid <= nxt_flit[`LPIF_CRC_VALID_POS];
    dstrm_crc       <= nxt_flit[`LPIF_CRC_LSB +: `LPIF_CRC_W];
    dstrm_dvalid    <= nxt_flit[`LPIF_DVALID_POS];
    dstrm_data      <= nxt_flit[`LPIF_DATA_LSB +: `LPIF_DATA_W];
    dstrm_protid    <= nxt_flit[`LPIF_PROTID_LSB +: `LPIF_PROTID_W];
    dstrm_state     <= nxt_flit[`LPIF_STATE_LSB +: `LPIF_STATE_W];
  endtask

  task automatic check_value(input string what, input wide_t exp, input wide_t act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_outputs();
    logic [PW-1:0] e0;
    logic [PW-1:0] e1;
    e0 = '0;
    e1 = '0;
    e0[`LPIF_PHY0_FLIT_W-1:0] = exp_phy_flit[`LPIF_PHY0_FLIT_W-1:0];
    e0[`LPIF_USERBIT_POS] = exp_stb;
    e1[`LPIF_PHY1_FLIT_W-1:0] = exp_phy_flit[`LPIF_PHY0_FLIT_W +: `LPIF_PHY1_FLIT_W];
    e1[`LPIF_USERBIT_POS] = exp_mrk;
    check_value("tx_phy0", wide_t'(e0), wide_t'(tx_phy0));
    check_value("tx_phy1", wide_t'(e1), wide_t'(tx_phy1));
    check_value("ustrm_state", wide_t'(exp_ustrm[`LPIF_STATE_LSB +: `LPIF_STATE_W]),
                wide_t'(ustrm_state));
    check_value("ustrm_protid", wide_t'(exp_ustrm[`LPIF_PROTID_LSB +: `LPIF_PROTID_W]),
                wide_t'(ustrm_protid));
    check_value("ustrm_data", wide_t'(exp_ustrm[`LPIF_DATA_LSB +: `LPIF_DATA_W]),
                wide_t'(ustrm_data));
    check_value("ustrm_dvalid", wide_t'(exp_ustrm[`LPIF_DVALID_POS]), wide_t'(ustrm_dvalid));
    check_value("ustrm_crc", wide_t'(exp_ustrm[`LPIF_CRC_LSB +: `LPIF_CRC_W]),
                wide_t'(ustrm_crc));
    check_value("ustrm_crc_valid", wide_t'(exp_ustrm[`LPIF_CRC_VALID_POS]),
                wide_t'(ustrm_crc_valid));
    check_value("ustrm_valid", wide_t'(exp_ustrm[`LPIF_VALID_POS]), wide_t'(ustrm_valid));
    check_value("tx status", wide_t'(exp_tx_cnt), wide_t'(tx_downstream_debug_status));
    check_value("rx status", wide_t'({exp_lost, exp_rx_cnt[30:0]}),
                wide_t'(rx_upstream_debug_status));
  endtask

  // Inputs change on the rising edge, outputs are checked on the falling one
  task automatic cycle();
    @(posedge clk);
    model_edge();
    drive_inputs();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic wait_for(input int sel, input string what);
    int   i;
    logic hit;
    hit = 1'b0;
    for (i = 0; i < WAIT_LIMIT && !hit; i++) begin
      cycle();
      case (sel)
        W_TX_FLIT: hit = tx_phy0[`LPIF_VALID_POS];
        W_RX_FLIT: hit = ustrm_valid;
        default:   hit = rx_upstream_debug_status[`LPIF_STATUS_W-1];
      endcase
    end
    if (!hit) begin
      $display("Timeout in %s: no %s within %0d cycles", test_name, what, WAIT_LIMIT);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("%s: passed", test_name);
      pass_tests++;
    end else begin
      $display("%s: failed with %0d errors", test_name, test_errs);
      fail_tests++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    lfsr = 32'h3f5fdc84;
    arst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    tx_stb_userbit = 1'b1;
    tx_mrk_userbit = 1'b0;
    dstrm_state = '0;
    dstrm_protid = '0;
    dstrm_data = '0;
    dstrm_dvalid = 1'b0;
    dstrm_crc = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid = 1'b0;
    delay_x_value = `LPIF_DELAY_W'(DLY_X);
    delay_xz_value = `LPIF_DELAY_W'(DLY_XZ);
    delay_yz_value = `LPIF_DELAY_W'(DLY_YZ);
    nxt_arst_n = 1'b0;
    nxt_tx_online = 1'b0;
    nxt_rx_online = 1'b0;
    nxt_stb = 1'b1;
    nxt_mrk = 1'b0;
    nxt_flit = '0;
    repeat (4) begin
      flit_q.push_back('0);
      txd_q.push_back(1'b0);
    end
    exp_rxd = 1'b0;
    exp_phy_flit = '0;
    exp_ustrm = '0;
    exp_stb = 1'b0;
    exp_mrk = 1'b0;
    stb_prev = 1'b0;
    mrk_prev = 1'b0;
    exp_err = 1'b0;
    exp_lost = 1'b0;
    exp_tx_cnt = '0;
    exp_rx_cnt = '0;
    tx_run = 0;
    rx_run = 0;
    edge_n = 0;
    tx_rise_edge = 0;
    rx_rise_edge = 0;
    pass_tests = 0;
    fail_tests = 0;

    // Two edges in reset, then a few idle cycles offline
    start_test("reset_values");
    cycle();
    nxt_arst_n = 1'b1;
    cycle();
    repeat (4) cycle();
    finish_test();

    // Tx delay xz + yz, one more cycle to the PHY register
    start_test("online_delay");
    nxt_flit = rand_bits(FW);
    nxt_flit[`LPIF_VALID_POS] = 1'b1;
    repeat (3) begin
      nxt_mrk = rand_bit();
      cycle();
    end
    nxt_tx_online = 1'b1;
    wait_for(W_TX_FLIT, "flit on tx_phy0");
    check_value("tx flit latency", wide_t'(DLY_XZ + DLY_YZ + 1),
                wide_t'(edge_n - tx_rise_edge));
    // Rx delay, then the upstream register
    nxt_rx_online = 1'b1;
    wait_for(W_RX_FLIT, "upstream flit");
    check_value("rx flit latency", wide_t'(DLY_X + 1), wide_t'(edge_n - rx_rise_edge));
    finish_test();

    start_test("random_loopback");
    repeat (200) begin
      nxt_flit = rand_bits(FW);
      nxt_mrk = rand_bit();
      cycle();
    end
    finish_test();

    // Empty pipeline on both sides, then count the valid flits driven
    start_test("debug_counters");
    nxt_flit = '0;
    repeat (6) cycle();
    tx_start = tx_downstream_debug_status;
    rx_start = {1'b0, rx_upstream_debug_status[30:0]};
    sent_valid = '0;
    repeat (50) begin
      nxt_flit = rand_bits(FW);
      sent_valid = sent_valid + {31'b0, nxt_flit[`LPIF_VALID_POS]};
      cycle();
    end
    nxt_flit = '0;
    repeat (6) cycle();
    check_value("tx count increase", wide_t'(sent_valid),
                wide_t'(tx_downstream_debug_status - tx_start));
    check_value("rx count increase", wide_t'(sent_valid),
                wide_t'({1'b0, rx_upstream_debug_status[30:0]} - rx_start));
    finish_test();

    start_test("user_bits");
    repeat (20) begin
      nxt_flit = rand_bits(FW);
      nxt_mrk = rand_bit();
      cycle();
    end
    nxt_stb = 1'b0;
    wait_for(W_STB_LOST, "strobe loss flag");
    nxt_stb = 1'b1;
    repeat (10) cycle();
    check_value("strobe loss flag", wide_t'(1'b1),
                wide_t'(rx_upstream_debug_status[`LPIF_STATUS_W-1]));
    finish_test();

    // Flit field gone on the second edge that sees tx_online low
    start_test("going_offline");
    nxt_flit = rand_bits(FW);
    nxt_flit[`LPIF_VALID_POS] = 1'b1;
    nxt_tx_online = 1'b0;
    repeat (3) cycle();
    check_value("tx flit field after drop", '0,
                wide_t'(tx_phy0[`LPIF_PHY0_FLIT_W-1:0]));
    // Both user bits keep toggling while tx is offline
    repeat (5) begin
      nxt_stb = rand_bit();
      nxt_mrk = rand_bit();
      cycle();
    end
    nxt_stb = 1'b1;
    nxt_tx_online = 1'b1;
    wait_for(W_TX_FLIT, "flit on tx_phy0 after restart");
    check_value("tx flit latency after restart", wide_t'(DLY_XZ + DLY_YZ + 1),
                wide_t'(edge_n - tx_rise_edge));
    repeat (4) cycle();
    finish_test();

    $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hw/lpif_pkg.sv
hw/lpif_auto_sync.sv
hw/lpif_flit_pack.sv
hw/lpif_phy_concat.sv
hw/lpif_link_top.sv
tb/lpif_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lpif_link_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG); then exit 1; fi; \
	if ! grep -q "TEST PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
